/* hdl/flash_rd_params.svh */
// sizing constants of the flash read pipeline, included by the package and the RTL modules
`ifndef FLASH_RD_PARAMS_SVH
`define FLASH_RD_PARAMS_SVH

// number of read buffers kept in front of the flash
`define FLASH_RD_NUM_BUF 4

// bus word width seen by the front end
`define FLASH_RD_BUS_W 32

// flash word width returned by the flash primitive
`define FLASH_RD_DATA_W 64

// bus side address counts bus words, its lowest bit picks the half of a flash word
`define FLASH_RD_BUS_ADDR_W 12

// page index width, a page holds 64 flash words
`define FLASH_RD_PAGE_W 4

// entries of the response order FIFO, this bounds the requests in flight
`define FLASH_RD_RSP_DEPTH 4

`endif

/* hdl/flash_rd_pkg.sv */
// shared types of the flash read pipeline, referenced by scoped name from every RTL module
`default_nettype none

`include "flash_rd_params.svh"

package flash_rd_pkg;

  // bus side and flash side addresses, the flash word address drops the half select bit
  typedef logic [`FLASH_RD_BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [`FLASH_RD_BUS_ADDR_W-2:0] flash_addr_t;

  typedef logic [`FLASH_RD_BUS_W-1:0]  bus_data_t;
  typedef logic [`FLASH_RD_DATA_W-1:0] flash_data_t;

  // one-hot vector over the read buffers
  typedef logic [`FLASH_RD_NUM_BUF-1:0] buf_sel_t;

  // wip marks a buffer whose flash read is still in progress
  typedef enum logic [1:0] {
    st_invalid = 2'b00,
    st_wip     = 2'b01,
    st_valid   = 2'b10
  } buf_state_e;

  // complete state of one read buffer
  typedef struct packed {
    buf_state_e  state;
    flash_addr_t addr;
    flash_data_t data;
  } rd_buf_t;

  // the response FIFO remembers which buffer and which half answers a request
  typedef struct packed {
    buf_sel_t buf_sel;
    logic     word_sel;
  } rsp_entry_t;

endpackage

`default_nettype wire

/* hdl/flash_rd_buffer.sv */
// one read buffer entry holding a flash word, instantiated once per buffer by the buffer control
`timescale 1ns/1ps
`default_nettype none

module flash_rd_buffer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      en_i,
  input  wire logic                      alloc_i,
  input  wire logic                      update_i,
  input  wire logic                      wipe_i,
  input  wire flash_rd_pkg::flash_addr_t addr_i,
  input  wire flash_rd_pkg::flash_data_t data_i,
  output flash_rd_pkg::rd_buf_t          buf_o
);

  flash_rd_pkg::buf_state_e  state_q;
  flash_rd_pkg::flash_addr_t addr_q;
  flash_rd_pkg::flash_data_t data_q;
  logic                      fill;

  // only a buffer waiting on its flash read takes the returned word
  assign fill = update_i && (state_q == flash_rd_pkg::st_wip);

  // a disabled buffer array or a hazard drops the entry back to invalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= flash_rd_pkg::st_invalid;
    end else if (!en_i || wipe_i) begin
      state_q <= flash_rd_pkg::st_invalid;
    end else if (alloc_i) begin
      state_q <= flash_rd_pkg::st_wip;
    end else if (fill) begin
      state_q <= flash_rd_pkg::st_valid;
    end
  end

  // address is captured at allocation, data when the flash word comes back
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      addr_q <= addr_i;
    end
    if (fill) begin
      data_q <= data_i;
    end
  end

  assign buf_o = {state_q, addr_q, data_q};

endmodule

`default_nettype wire

/* hdl/flash_rd_buf_ctrl.sv */
// read buffer array with hit match, hazard invalidation and victim choice for the read pipeline
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_params.svh"

module flash_rd_buf_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      buf_en_i,
  input  wire logic                      req_i,
  input  wire logic                      prog_i,
  input  wire logic                      pg_erase_i,
  input  wire logic                      bk_erase_i,
  input  wire flash_rd_pkg::bus_addr_t   addr_i,
  input  wire flash_rd_pkg::buf_sel_t    alloc_i,
  input  wire flash_rd_pkg::buf_sel_t    update_i,
  input  wire flash_rd_pkg::flash_data_t data_i,
  output flash_rd_pkg::buf_sel_t         hit_o,
  output flash_rd_pkg::buf_sel_t         victim_o,
  output logic                           no_match_o,
  output flash_rd_pkg::rd_buf_t          bufs_o [`FLASH_RD_NUM_BUF]
);

  localparam int NumBuf = `FLASH_RD_NUM_BUF;
  localparam int PtrW   = $clog2(NumBuf);
  localparam int PageW  = `FLASH_RD_PAGE_W;
  // flash words per page is 2**WordW, the page field sits right above
  localparam int WordW  = 6;

  flash_rd_pkg::flash_addr_t word_addr;
  flash_rd_pkg::buf_sel_t    buf_valid;
  flash_rd_pkg::buf_sel_t    buf_wip;
  flash_rd_pkg::buf_sel_t    buf_invalid;
  flash_rd_pkg::buf_sel_t    hazard;
  flash_rd_pkg::buf_sel_t    inv_pick;
  flash_rd_pkg::buf_sel_t    valid_pick;
  logic [PtrW-1:0]           rr_q;

  assign word_addr = addr_i[`FLASH_RD_BUS_ADDR_W-1:1];

  //////////////////////////////////////////////////
  // match and hazard detection
  //////////////////////////////////////////////////

  // a wip buffer also matches, its answer simply waits for the fill
  // hazards only ever hit valid buffers since they are issued while idle
  always_comb begin
    for (int i = 0; i < NumBuf; i++) begin
      buf_valid[i]   = bufs_o[i].state == flash_rd_pkg::st_valid;
      buf_wip[i]     = bufs_o[i].state == flash_rd_pkg::st_wip;
      buf_invalid[i] = bufs_o[i].state == flash_rd_pkg::st_invalid;
      hit_o[i]       = req_i && buf_en_i && (buf_valid[i] || buf_wip[i]) &&
                       (bufs_o[i].addr == word_addr);
      hazard[i]      = buf_valid[i] &&
                       (bk_erase_i ||
                        (prog_i && (bufs_o[i].addr == word_addr)) ||
                        (pg_erase_i &&
                         (bufs_o[i].addr[WordW +: PageW] == addr_i[WordW+1 +: PageW])));
    end
  end

  assign no_match_o = ~|hit_o;

  //////////////////////////////////////////////////
  // victim selection
  //////////////////////////////////////////////////

  // lowest invalid buffer first, the descending loop leaves the lowest one set
  always_comb begin
    inv_pick = '0;
    for (int i = NumBuf - 1; i >= 0; i--) begin
      if (buf_invalid[i]) begin
        inv_pick    = '0;
        inv_pick[i] = 1'b1;
      end
    end
  end

  // otherwise the first valid buffer at or after the round-robin pointer
  always_comb begin
    int idx;
    valid_pick = '0;
    for (int k = NumBuf - 1; k >= 0; k--) begin
      idx = (int'(rr_q) + k) % NumBuf;
      if (buf_valid[idx]) begin
        valid_pick      = '0;
        valid_pick[idx] = 1'b1;
      end
    end
  end

  assign victim_o = |inv_pick ? inv_pick : valid_pick;

  // every issued flash read comes with an allocation, so the pointer moves on those
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (|alloc_i) begin
      rr_q <= rr_q + 1'b1;
    end
  end

  for (genvar i = 0; i < NumBuf; i++) begin : gen_bufs
    flash_rd_buffer u_buf (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .en_i     (buf_en_i),
      .alloc_i  (alloc_i[i]),
      .update_i (update_i[i]),
      .wipe_i   (hazard[i]),
      .addr_i   (word_addr),
      .data_i   (data_i),
      .buf_o    (bufs_o[i])
    );
  end

endmodule

`default_nettype wire

/* hdl/flash_rd_rsp_fifo.sv */
// response order FIFO of the read pipeline, one entry per accepted request in request order
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_params.svh"

module flash_rd_rsp_fifo (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     push_i,
  input  wire flash_rd_pkg::rsp_entry_t wdata_i,
  input  wire logic                     pop_i,
  output logic                          full_o,
  output logic                          valid_o,
  output flash_rd_pkg::rsp_entry_t      rdata_o
);

  localparam int Depth = `FLASH_RD_RSP_DEPTH;
  localparam int AddrW = $clog2(Depth);

  flash_rd_pkg::rsp_entry_t mem_q [Depth];
  // pointers carry one extra wrap bit to tell full from empty
  logic [AddrW:0]           wr_ptr_q;
  logic [AddrW:0]           rd_ptr_q;
  logic                     push;
  logic                     pop;

  assign push = push_i && !full_o;
  assign pop  = pop_i && valid_o;

  assign valid_o = wr_ptr_q != rd_ptr_q;
  assign full_o  = (wr_ptr_q[AddrW] != rd_ptr_q[AddrW]) &&
                   (wr_ptr_q[AddrW-1:0] == rd_ptr_q[AddrW-1:0]);

  // no pass-through, a pushed entry shows at the head one cycle later
  assign rdata_o = mem_q[rd_ptr_q[AddrW-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[AddrW-1:0]] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/flash_rd_stage.sv */
// flash read stage of the read pipeline, decides acceptance and tracks the one outstanding read
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_params.svh"

module flash_rd_stage (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire flash_rd_pkg::bus_addr_t addr_i,
  input  wire logic                    no_match_i,
  input  wire flash_rd_pkg::buf_sel_t  victim_i,
  input  wire flash_rd_pkg::buf_sel_t  hit_i,
  input  wire logic                    buf_en_i,
  input  wire logic                    fifo_full_i,
  input  wire logic                    flash_ack_i,
  input  wire logic                    flash_done_i,
  output logic                         rdy_o,
  output logic                         flash_req_o,
  output flash_rd_pkg::flash_addr_t    flash_addr_o,
  output flash_rd_pkg::buf_sel_t       alloc_o,
  output flash_rd_pkg::buf_sel_t       update_o,
  output logic                         push_o,
  output flash_rd_pkg::rsp_entry_t     entry_o,
  output logic                         fill_valid_o
);

  logic                   active_q;
  logic                   busy_q;
  logic                   fill_q;
  flash_rd_pkg::buf_sel_t alloc_q;
  flash_rd_pkg::buf_sel_t update_q;
  logic                   rd_done;
  logic                   flash_rdy;
  logic                   room;
  logic                   accept;

  // done is only ours while a read is outstanding
  assign rd_done   = busy_q && flash_done_i;
  assign flash_rdy = !busy_q || rd_done;
  // nothing is taken before the first cycle after reset release
  assign room      = active_q && !fifo_full_i;

  // a miss needs the flash to take the read in the same cycle, a hit only needs FIFO space
  assign flash_req_o  = req_i && no_match_i && flash_rdy && room;
  assign rdy_o        = no_match_i ? (flash_ack_i && flash_rdy && room) : room;
  assign accept       = req_i && rdy_o;
  assign flash_addr_o = addr_i[`FLASH_RD_BUS_ADDR_W-1:1];

  // with buffers disabled a miss still reads the flash but claims no buffer
  assign alloc_o = (accept && no_match_i && buf_en_i) ? victim_i : '0;

  assign push_o  = accept;
  assign entry_o = {(no_match_i ? victim_i : hit_i), addr_i[0]};

  // the returned word is registered in the top, so the fill is presented one cycle later
  assign update_o     = update_q;
  assign fill_valid_o = fill_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      busy_q   <= 1'b0;
      fill_q   <= 1'b0;
      alloc_q  <= '0;
      update_q <= '0;
    end else begin
      active_q <= 1'b1;
      fill_q   <= rd_done;
      update_q <= rd_done ? alloc_q : '0;
      // a new read may start in the very cycle the previous one completes
      if (flash_req_o && flash_ack_i) begin
        busy_q  <= 1'b1;
        alloc_q <= alloc_o;
      end else if (rd_done) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/flash_rd_top.sv */
// top of the flash read pipeline, connects buffers, flash stage and response FIFO to both sides
`timescale 1ns/1ps
`default_nettype none

`include "flash_rd_params.svh"

module flash_rd_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      buf_en_i,
  input  wire logic                      req_i,
  input  wire logic                      prog_i,
  input  wire logic                      pg_erase_i,
  input  wire logic                      bk_erase_i,
  input  wire flash_rd_pkg::bus_addr_t   addr_i,
  input  wire logic                      flash_ack_i,
  input  wire logic                      flash_done_i,
  input  wire flash_rd_pkg::flash_data_t flash_data_i,
  output logic                           rdy_o,
  output logic                           data_valid_o,
  output flash_rd_pkg::bus_data_t        data_o,
  output logic                           idle_o,
  output logic                           flash_req_o,
  output flash_rd_pkg::flash_addr_t      flash_addr_o
);

  localparam int NumBuf    = `FLASH_RD_NUM_BUF;
  localparam int WordsPerW = `FLASH_RD_DATA_W / `FLASH_RD_BUS_W;

  logic                              buf_en_q;
  flash_rd_pkg::buf_sel_t            hit;
  flash_rd_pkg::buf_sel_t            victim;
  flash_rd_pkg::buf_sel_t            alloc;
  flash_rd_pkg::buf_sel_t            update;
  flash_rd_pkg::buf_sel_t            buf_rsp;
  logic                              no_match;
  flash_rd_pkg::rd_buf_t             bufs [NumBuf];
  logic                              fifo_full;
  logic                              fifo_valid;
  logic                              push;
  logic                              fill_valid;
  logic                              fill_rsp;
  flash_rd_pkg::rsp_entry_t          entry;
  flash_rd_pkg::rsp_entry_t          head;
  flash_rd_pkg::flash_data_t         fill_data_q;
  flash_rd_pkg::flash_data_t         rsp_word;
  logic [WordsPerW-1:0][`FLASH_RD_BUS_W-1:0] bus_words;

  // the buffer enable only follows its input while nothing is in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_en_q <= 1'b0;
    end else if (idle_o) begin
      buf_en_q <= buf_en_i;
    end
  end

  // returned flash word, feeds both the buffer fill and the direct answer
  always_ff @(posedge clk_i) begin
    if (flash_done_i) begin
      fill_data_q <= flash_data_i;
    end
  end

  flash_rd_buf_ctrl u_buf_ctrl (
    .clk_i, .rst_ni, .buf_en_i (buf_en_q), .req_i, .prog_i, .pg_erase_i, .bk_erase_i,
    .addr_i, .alloc_i (alloc), .update_i (update), .data_i (fill_data_q),
    .hit_o (hit), .victim_o (victim), .no_match_o (no_match), .bufs_o (bufs)
  );

  flash_rd_stage u_stage (
    .clk_i, .rst_ni, .req_i, .addr_i, .no_match_i (no_match), .victim_i (victim),
    .hit_i (hit), .buf_en_i (buf_en_q), .fifo_full_i (fifo_full), .flash_ack_i,
    .flash_done_i, .rdy_o, .flash_req_o, .flash_addr_o, .alloc_o (alloc),
    .update_o (update), .push_o (push), .entry_o (entry), .fill_valid_o (fill_valid)
  );

  flash_rd_rsp_fifo u_rsp_fifo (
    .clk_i, .rst_ni, .push_i (push), .wdata_i (entry), .pop_i (data_valid_o),
    .full_o (fifo_full), .valid_o (fifo_valid), .rdata_o (head)
  );

  //////////////////////////////////////////////////
  // response selection
  //////////////////////////////////////////////////

  // the head is answered by its buffer once that buffer holds valid data
  always_comb begin
    buf_rsp  = '0;
    rsp_word = fill_data_q;
    for (int i = 0; i < NumBuf; i++) begin
      if (buf_en_q && fifo_valid && head.buf_sel[i] &&
          (bufs[i].state == flash_rd_pkg::st_valid)) begin
        buf_rsp[i] = 1'b1;
        rsp_word   = bufs[i].data;
      end
    end
  end

  // a fill answers the head directly when it targets the head buffer, always when disabled
  assign fill_rsp     = fifo_valid && fill_valid && (!buf_en_q || (head.buf_sel == update));
  assign data_valid_o = fill_rsp || |buf_rsp;

  assign bus_words = rsp_word;
  assign data_o    = bus_words[head.word_sel];

  // an empty response FIFO means no read is pending anywhere
  assign idle_o = !fifo_valid;

endmodule

`default_nettype wire

/* tests/flash_rd_flash_model.sv */
// behavioral flash primitive for the read pipeline testbench, with random ack and done delays
`timescale 1ns/1ps
`default_nettype none

module flash_rd_flash_model (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,
  input  wire flash_rd_pkg::flash_addr_t addr_i,
  output logic                           ack_o,
  output logic                           done_o,
  output flash_rd_pkg::flash_data_t      data_o,
  output int                             rd_count_o
);

  localparam int Words = 2 ** $bits(flash_rd_pkg::flash_addr_t);
  // 64 flash words per page
  localparam int PageShift = 6;
  localparam flash_rd_pkg::flash_data_t FillMask = 64'hc3c3_0000_3c3c_0000;

  flash_rd_pkg::flash_data_t mem [Words];
  flash_rd_pkg::flash_addr_t addr_q;
  logic                      pending_q;
  int                        ack_wait_q;
  int                        done_wait_q;
  integer                    seed = 32'h2f5b_6273;

  // every word starts as its own address replicated four times, then XORed with a fixed mask
  initial begin
    for (int a = 0; a < Words; a++) begin
      mem[a] = {4{a[15:0]}} ^ FillMask;
    end
  end

  // the word of a read is returned together with the single done pulse
  assign done_o = pending_q && (done_wait_q == 0);
  assign data_o = done_o ? mem[addr_q] : '0;
  // a new read is taken in the same cycle, at the earliest when the previous one completes
  assign ack_o  = req_i && (ack_wait_q == 0) && (!pending_q || done_o);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      ack_wait_q  <= 0;
      done_wait_q <= 0;
      rd_count_o  <= 0;
    end else begin
      if (pending_q && (done_wait_q != 0)) begin
        done_wait_q <= done_wait_q - 1;
      end
      if (done_o) begin
        pending_q <= 1'b0;
      end
      // the ack delay only runs down while a request is waiting
      if (req_i && !ack_o && (ack_wait_q != 0)) begin
        ack_wait_q <= ack_wait_q - 1;
      end
      // done follows 1 to 5 cycles after the ack, the next ack waits 0 to 3 cycles
      if (ack_o) begin
        pending_q   <= 1'b1;
        addr_q      <= addr_i;
        done_wait_q <= $unsigned($random(seed)) % 5;
        ack_wait_q  <= $unsigned($random(seed)) % 4;
        rd_count_o  <= rd_count_o + 1;
      end
    end
  end

  task automatic write_word(input flash_rd_pkg::flash_addr_t a,
                            input flash_rd_pkg::flash_data_t d);
    mem[a] = d;
  endtask

  // erased flash reads back as all ones
  task automatic erase_page(input flash_rd_pkg::flash_addr_t a);
    for (int i = 0; i < Words; i++) begin
      if ((i >> PageShift) == (int'(a) >> PageShift)) begin
        mem[i] = '1;
      end
    end
  endtask

  task automatic erase_bank();
    for (int i = 0; i < Words; i++) begin
      mem[i] = '1;
    end
  endtask

endmodule

`default_nettype wire

/* tests/flash_rd_tb.sv */
// testbench of the flash read pipeline, runs the operation list of the test data file on the DUT
`timescale 1ns/1ps
`default_nettype none

module flash_rd_tb;

  localparam int ClkPeriod   = 100;
  // outputs are sampled a quarter period after the falling edge
  localparam int SettleDly   = ClkPeriod / 4;
  localparam int CyclesPerOp = 40;

  // operation codes of the test data file
  localparam int OpReadHit  = 0;
  localparam int OpReadMiss = 1;
  localparam int OpProg     = 2;
  localparam int OpPgErase  = 3;
  localparam int OpBkErase  = 4;
  localparam int OpEnable   = 5;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      buf_en;
  logic                      req;
  logic                      prog;
  logic                      pg_erase;
  logic                      bk_erase;
  flash_rd_pkg::bus_addr_t   addr;
  logic                      flash_ack;
  logic                      flash_done;
  flash_rd_pkg::flash_data_t flash_data;
  logic                      rdy;
  logic                      data_valid;
  flash_rd_pkg::bus_data_t   data;
  logic                      idle;
  logic                      flash_req;
  flash_rd_pkg::flash_addr_t flash_addr;
  int                        flash_reads;

  int                        op_code [$];
  flash_rd_pkg::bus_addr_t   op_addr [$];
  flash_rd_pkg::flash_data_t op_val [$];
  // expected bus words in request order
  flash_rd_pkg::bus_data_t   exp_q [$];
  int                        exp_misses = 0;
  int                        data_errs = 0;
  int                        count_errs = 0;
  int                        other_errs = 0;
  bit                        run_started = 1'b0;

  flash_rd_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .buf_en_i     (buf_en),
    .req_i        (req),
    .prog_i       (prog),
    .pg_erase_i   (pg_erase),
    .bk_erase_i   (bk_erase),
    .addr_i       (addr),
    .flash_ack_i  (flash_ack),
    .flash_done_i (flash_done),
    .flash_data_i (flash_data),
    .rdy_o        (rdy),
    .data_valid_o (data_valid),
    .data_o       (data),
    .idle_o       (idle),
    .flash_req_o  (flash_req),
    .flash_addr_o (flash_addr)
  );

  flash_rd_flash_model u_flash (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (flash_req),
    .addr_i     (flash_addr),
    .ack_o      (flash_ack),
    .done_o     (flash_done),
    .data_o     (flash_data),
    .rd_count_o (flash_reads)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // checks and run control
  //////////////////////////////////////////////////

  task automatic check_data(input flash_rd_pkg::bus_data_t got,
                            input flash_rd_pkg::bus_data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("FAIL %0t: read data 0x%08h, expected 0x%08h", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got !== exp) begin
      count_errs++;
      $display("FAIL %0t: %0d flash reads issued, expected %0d", $time, got, exp);
    end
  endtask

  task automatic end_run();
    $display("errors: data %0d, count %0d, other %0d", data_errs, count_errs, other_errs);
    if (data_errs + count_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // responses cannot be stalled, so every valid cycle is checked against the oldest read
  always @(negedge clk_i) begin
    if (rst_ni && data_valid) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("a response arrived at %0t while no read was pending", $time);
      end else begin
        check_data(data, exp_q.pop_front());
      end
    end
  end

  // the run may last CyclesPerOp cycles for each data line
  initial begin
    wait (run_started);
    repeat (op_code.size() * CyclesPerOp) @(posedge clk_i);
    other_errs++;
    $display("timeout at %0t with %0d reads still waiting for data", $time, exp_q.size());
    end_run();
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // lines that do not start with three numbers are comments
  task automatic load_ops();
    int                        fd;
    int                        code;
    flash_rd_pkg::bus_addr_t   adr;
    flash_rd_pkg::flash_data_t val;
    logic [8*200-1:0]          line;
    fd = $fopen("tests/flash_rd_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file tests/flash_rd_testdata.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%d %h %h", code, adr, val) == 3) begin
          op_code.push_back(code);
          op_addr.push_back(adr);
          op_val.push_back(val);
        end
      end
    end
    $fclose(fd);
  endtask

  // holds the request until the DUT takes it, the response is checked by the monitor
  task automatic issue_read(input flash_rd_pkg::bus_addr_t adr,
                            input flash_rd_pkg::bus_data_t exp);
    exp_q.push_back(exp);
    req  = 1'b1;
    addr = adr;
    #(SettleDly);
    while (!rdy) begin
      @(negedge clk_i);
      #(SettleDly);
    end
    @(negedge clk_i);
    req = 1'b0;
  endtask

  // program, erase and enable changes wait for an empty pipeline
  task automatic drain_and_count();
    while (!idle) @(negedge clk_i);
    check_count(flash_reads, exp_misses);
  endtask

  task automatic run_op(input int code, input flash_rd_pkg::bus_addr_t adr,
                        input flash_rd_pkg::flash_data_t val);
    case (code)
      OpReadHit: begin
        issue_read(adr, val[31:0]);
      end
      OpReadMiss: begin
        exp_misses++;
        issue_read(adr, val[31:0]);
      end
      OpProg: begin
        drain_and_count();
        u_flash.write_word(adr[11:1], val);
        prog = 1'b1;
        addr = adr;
        @(negedge clk_i);
        prog = 1'b0;
      end
      OpPgErase: begin
        drain_and_count();
        u_flash.erase_page(adr[11:1]);
        pg_erase = 1'b1;
        addr     = adr;
        @(negedge clk_i);
        pg_erase = 1'b0;
      end
      OpBkErase: begin
        drain_and_count();
        u_flash.erase_bank();
        bk_erase = 1'b1;
        @(negedge clk_i);
        bk_erase = 1'b0;
      end
      OpEnable: begin
        // the DUT takes the new enable on the next edge since it is idle
        drain_and_count();
        buf_en = val[0];
        @(negedge clk_i);
      end
      default: begin
        other_errs++;
        $display("unknown operation code %0d in the test data file", code);
      end
    endcase
  endtask

  initial begin
    rst_ni   = 1'b0;
    buf_en   = 1'b0;
    req      = 1'b0;
    prog     = 1'b0;
    pg_erase = 1'b0;
    bk_erase = 1'b0;
    addr     = '0;
    load_ops();
    if (op_code.size() == 0) begin
      other_errs++;
      $display("no operations were loaded, nothing to run");
      end_run();
    end else begin
      run_started = 1'b1;
      repeat (3) @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);
      for (int i = 0; i < op_code.size(); i++) begin
        run_op(op_code[i], op_addr[i], op_val[i]);
      end
      drain_and_count();
      if (exp_q.size() != 0) begin
        other_errs++;
        $display("%0d reads received no response", exp_q.size());
      end
      end_run();
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/flash_rd_pkg.sv
hdl/flash_rd_buffer.sv
hdl/flash_rd_buf_ctrl.sv
hdl/flash_rd_rsp_fifo.sv
hdl/flash_rd_stage.sv
hdl/flash_rd_top.sv
tests/flash_rd_flash_model.sv
tests/flash_rd_tb.sv

/* Bender.yml */
package:
  name: flash_rd

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/flash_rd_pkg.sv
      - hdl/flash_rd_buffer.sv
      - hdl/flash_rd_buf_ctrl.sv
      - hdl/flash_rd_rsp_fifo.sv
      - hdl/flash_rd_stage.sv
      - hdl/flash_rd_top.sv
  - target: test
    files:
      - tests/flash_rd_flash_model.sv
      - tests/flash_rd_tb.sv

/* tests/flash_rd_testdata.txt */
// op: 0 read hit, 1 read miss, 2 program, 3 page erase, 4 bank erase, 5 buffer enable
// addr: bus word address in hex; value: expected bus word of a read, flash word of a program
5 000 1
1 008 3c380004
0 009 c3c70004
1 00a 3c390005
0 00a 3c390005
0 008 3c380004
1 00d c3c50006
1 081 c3830040
2 00a 0123456789abcdef
1 00a 89abcdef
0 00b 01234567
3 080 0
1 081 ffffffff
0 080 ffffffff
0 009 c3c70004
// more distinct words than buffers
1 020 3c2c0010
0 021 c3d30010
1 022 3c2d0011
0 023 c3d20011
1 024 3c2e0012
1 027 c3d00013
1 028 3c280014
0 028 3c280014
1 009 c3c70004
0 025 c3d10012
// bank erase, then buffers off
4 000 0
1 028 ffffffff
0 029 ffffffff
1 025 ffffffff
2 030 76543210fedcba98
5 000 0
1 030 fedcba98
1 031 76543210
1 031 76543210
5 000 1
1 030 fedcba98
0 031 76543210
